// File: batch_pkg.sv
`default_nettype none

package batch_pkg;

    // Narrow item and the wide word packed from BATCH_LEN items
    localparam int ITEM_W = 8;
    localparam int BATCH_LEN = 4;
    localparam int WORD_W = ITEM_W * BATCH_LEN;

    // In-batch item counter
    localparam int CNT_W = 2;

    typedef logic [ITEM_W-1:0] item_t;

    // Slot BATCH_LEN-1 holds the oldest item
    typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int MEM_DEPTH_LOG2 = 4;
    localparam int MEM_DEPTH = 1 << MEM_DEPTH_LOG2;

    // 0 for small-RAM style, 2 for block-RAM style
    localparam int MEM_READ_STAGES = 0;

    typedef logic [MEM_DEPTH_LOG2-1:0] addr_t;

    localparam int OCC_W = MEM_DEPTH_LOG2 + 1;

endpackage

`default_nettype wire

// File: memory_block.sv
`timescale 1ns/1ps
`default_nettype none

module memory_block #(
    parameter int READ_STAGES = mem_pkg::MEM_READ_STAGES
) (
    input  logic              clk,

    input  logic              write_enable,
    input  mem_pkg::addr_t    write_addr,
    input  batch_pkg::word_t  data_in,

    input  logic              read_addr_stall,
    input  mem_pkg::addr_t    read_addr,
    output batch_pkg::word_t  data_out
);

    batch_pkg::word_t ram [mem_pkg::MEM_DEPTH];

    logic             write_enable_q;
    mem_pkg::addr_t   write_addr_q;
    batch_pkg::word_t write_data_q;

    mem_pkg::addr_t   read_addr_q;
    logic             read_fresh;
    batch_pkg::word_t array_word;

    // Write port is registered, the array takes the word one cycle later
    always_ff @(posedge clk) begin
        write_enable_q <= write_enable;
        write_addr_q <= write_addr;
        write_data_q <= data_in;
        if (write_enable_q) begin
            ram[write_addr_q] <= write_data_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!read_addr_stall) begin
            read_addr_q <= read_addr;
        end
        read_fresh <= !read_addr_stall;
    end

    assign array_word = ram[read_addr_q];

    if (READ_STAGES == 0) begin : g_no_pipe
        assign data_out = array_word;
    end else begin : g_pipe
        batch_pkg::word_t stage [READ_STAGES];

        always_ff @(posedge clk) begin
            stage[0] <= array_word;
            for (int i = 1; i < READ_STAGES; i++) begin
                stage[i] <= stage[i-1];
            end
        end

        assign data_out = stage[READ_STAGES-1];
    end

    // Array is sampled in the cycle after the address loads
    a_no_rdw: assert property (@(posedge clk)
        read_fresh && write_enable_q |-> write_addr_q != read_addr_q)
        else $error("write lands on the word being read");

endmodule

`default_nettype wire

// File: packing_shift_register.sv
`timescale 1ns/1ps
`default_nettype none

module packing_shift_register (
    input  logic              clk,
    input  logic              shift,
    input  batch_pkg::item_t  item_in,
    output batch_pkg::word_t  packed_word
);

    // Slot 0 is the newest item
    batch_pkg::item_t slots [batch_pkg::BATCH_LEN];

    always_ff @(posedge clk) begin
        if (shift) begin
            slots[0] <= item_in;
            for (int i = 1; i < batch_pkg::BATCH_LEN; i++) begin
                slots[i] <= slots[i-1];
            end
        end
    end

    for (genvar g = 0; g < batch_pkg::BATCH_LEN; g++) begin : g_pack
        assign packed_word[g*batch_pkg::ITEM_W +: batch_pkg::ITEM_W] = slots[g];
    end

endmodule

`default_nettype wire

// File: unpacking_shift_register.sv
`timescale 1ns/1ps
`default_nettype none

module unpacking_shift_register (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_batch,
    input  batch_pkg::word_t  word_in,
    output batch_pkg::item_t  item_out,
    output logic              item_out_valid
);

    batch_pkg::item_t shifter [batch_pkg::BATCH_LEN-1];

    // Items still to send, counting the current cycle
    logic [batch_pkg::CNT_W-1:0] left;

    always_ff @(posedge clk) begin
        for (int i = 0; i < batch_pkg::BATCH_LEN - 1; i++) begin
            if (start_batch) begin
                shifter[i] <= word_in[i*batch_pkg::ITEM_W +: batch_pkg::ITEM_W];
            end else if (i > 0) begin
                shifter[i] <= shifter[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            left <= '0;
        end else if (start_batch) begin
            left <= batch_pkg::CNT_W'(batch_pkg::BATCH_LEN - 1);
        end else if (left != '0) begin
            left <= left - 1'b1;
        end
    end

    // Oldest slot goes straight out on the start cycle
    assign item_out = start_batch ? word_in[batch_pkg::WORD_W-1 -: batch_pkg::ITEM_W]
                                  : shifter[batch_pkg::BATCH_LEN-2];
    assign item_out_valid = start_batch || (left != '0);

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        start_batch |-> left == '0)
        else $error("batch start while a batch is still being emitted");

endmodule

`default_nettype wire

// File: batch_fifo_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module batch_fifo_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            item_valid,
    input  logic            drain_hold,
    output logic            take,
    output logic            wr_en,
    output mem_pkg::addr_t  wr_addr,
    output logic            rd_stall,
    output mem_pkg::addr_t  rd_addr,
    output logic            start_batch,
    output logic            full,
    empty
);

    typedef logic [mem_pkg::OCC_W-1:0] occ_t;

    logic [batch_pkg::CNT_W-1:0] item_cnt;
    logic                        batch_done;
    logic                        wr_land;
    mem_pkg::addr_t              wr_ptr;
    mem_pkg::addr_t              rd_ptr;
    occ_t                        occ;
    occ_t                        words_total;
    logic                        rd_issue;
    logic [mem_pkg::MEM_READ_STAGES:0] in_flight;
    logic [batch_pkg::CNT_W-1:0] emit_left;

    assign batch_done = item_cnt == batch_pkg::CNT_W'(batch_pkg::BATCH_LEN - 1);

    // Room for one more word only after the current one completes
    assign words_total = occ + occ_t'(wr_en) + occ_t'(wr_land);
    assign full = (words_total == occ_t'(mem_pkg::MEM_DEPTH)) && batch_done;
    assign take = item_valid && !full;

    always_ff @(posedge clk) begin
        if (rst) begin
            item_cnt <= '0;
            wr_en <= 1'b0;
            wr_land <= 1'b0;
            wr_ptr <= '0;
        end else begin
            wr_en <= take && batch_done;
            wr_land <= wr_en;
            if (take) begin
                item_cnt <= batch_done ? '0 : item_cnt + 1'b1;
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // Next batch may start once the current one has ended
    assign rd_issue = (occ != '0) && !drain_hold && !(|in_flight)
                      && (int'(emit_left) <= mem_pkg::MEM_READ_STAGES + 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            occ <= '0;
            in_flight <= '0;
            emit_left <= '0;
        end else begin
            // Count a word only once the array holds it
            occ <= occ + occ_t'(wr_land) - occ_t'(rd_issue);
            if (rd_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            in_flight[0] <= rd_issue;
            for (int i = 1; i <= mem_pkg::MEM_READ_STAGES; i++) begin
                in_flight[i] <= in_flight[i-1];
            end
            if (start_batch) begin
                emit_left <= batch_pkg::CNT_W'(batch_pkg::BATCH_LEN - 1);
            end else if (emit_left != '0) begin
                emit_left <= emit_left - 1'b1;
            end
        end
    end

    assign start_batch = in_flight[mem_pkg::MEM_READ_STAGES];
    assign rd_stall = !rd_issue;
    assign rd_addr = rd_ptr;
    assign wr_addr = wr_ptr;

    assign empty = (words_total == '0) && !(|in_flight) && (emit_left == '0);

    a_occ_bound: assert property (@(posedge clk) disable iff (rst)
        occ <= occ_t'(mem_pkg::MEM_DEPTH))
        else $error("occupancy above memory depth");

endmodule

`default_nettype wire

// File: batch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module batch_fifo (
    input  logic              clk,
    input  logic              rst,
    input  batch_pkg::item_t  item_in,
    input  logic              item_valid,
    input  logic              drain_hold,
    output batch_pkg::item_t  item_out,
    output logic              item_out_valid,
    output logic              full,
    output logic              empty
);

    logic             take;
    logic             wr_en;
    mem_pkg::addr_t   wr_addr;
    logic             rd_stall;
    mem_pkg::addr_t   rd_addr;
    logic             start_batch;
    batch_pkg::word_t packed_word;
    batch_pkg::word_t mem_word;

    batch_fifo_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .item_valid  (item_valid),
        .drain_hold  (drain_hold),
        .take        (take),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .rd_stall    (rd_stall),
        .rd_addr     (rd_addr),
        .start_batch (start_batch),
        .full        (full),
        .empty       (empty)
    );

    // Packer holds its word until the next take
    packing_shift_register u_pack (
        .clk         (clk),
        .shift       (take),
        .item_in     (item_in),
        .packed_word (packed_word)
    );

    memory_block #(
        .READ_STAGES (mem_pkg::MEM_READ_STAGES)
    ) u_mem (
        .clk             (clk),
        .write_enable    (wr_en),
        .write_addr      (wr_addr),
        .data_in         (packed_word),
        .read_addr_stall (rd_stall),
        .read_addr       (rd_addr),
        .data_out        (mem_word)
    );

    unpacking_shift_register u_unpack (
        .clk            (clk),
        .rst            (rst),
        .start_batch    (start_batch),
        .word_in        (mem_word),
        .item_out       (item_out),
        .item_out_valid (item_out_valid)
    );

endmodule

`default_nettype wire

// File: tb_batch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tb_batch_fifo;

    localparam int EMPTY_TIMEOUT = 2000;
    localparam int HOLD_LIMIT = batch_pkg::BATCH_LEN + mem_pkg::MEM_READ_STAGES;
    localparam int NUM_ROWS = 9;

    typedef struct packed {
        logic [7:0] n_items;
        logic       hold;
        logic [7:0] idle;
        logic       exp_full;
        logic       drain;
    } row_t;

    logic             clk;
    logic             rst;
    batch_pkg::item_t item_in;
    logic             item_valid;
    logic             drain_hold;
    batch_pkg::item_t item_out;
    logic             item_out_valid;
    logic             full;
    logic             empty;

    row_t             rows [NUM_ROWS];
    batch_pkg::item_t scoreboard [$];
    logic [15:0]      lfsr;
    int               accepted;
    int               emitted;
    int               run_len;
    int               hold_cnt;
    int               item_errs;
    int               flag_errs;
    int               timeouts;

    batch_fifo DUT (
        .clk            (clk),
        .rst            (rst),
        .item_in        (item_in),
        .item_valid     (item_valid),
        .drain_hold     (drain_hold),
        .item_out       (item_out),
        .item_out_valid (item_out_valid),
        .full           (full),
        .empty          (empty)
    );

    always #4 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic next_item(output batch_pkg::item_t v);
        v = '0;
        for (int i = 0; i < batch_pkg::ITEM_W; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[batch_pkg::ITEM_W-2:0], lfsr[0]};
        end
    endtask

    task automatic check_item(input batch_pkg::item_t got, input batch_pkg::item_t exp,
                              input string what);
        if (got !== exp) begin
            $display("ERR %0t %s: got %h expected %h", $time, what, got, exp);
            item_errs++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t %s: got %b expected %b", $time, what, got, exp);
            flag_errs++;
        end
    endtask

    task automatic wait_empty();
        int  cycles;
        bit  seen;
        cycles = 0;
        seen = 0;
        while (!seen && cycles < EMPTY_TIMEOUT) begin
            @(posedge clk);
            #1;
            seen = empty;
            cycles++;
        end
        if (!seen) begin
            $display("Timed out after %0d cycles waiting for empty to go high", cycles);
            timeouts++;
        end
    endtask

    task automatic apply_row(input row_t row);
        batch_pkg::item_t v;
        for (int i = 0; i < int'(row.n_items); i++) begin
            @(posedge clk);
            #1;
            next_item(v);
            drain_hold = row.hold;
            item_in = v;
            item_valid = 1'b1;
            // Full does not depend on this cycle's inputs
            if (!full) begin
                scoreboard.push_back(v);
                accepted++;
            end
        end
        @(posedge clk);
        #1;
        drain_hold = row.hold;
        item_valid = 1'b0;
        check_flag(full, row.exp_full, "full after offering items");
        repeat (int'(row.idle)) @(posedge clk);
        if (row.drain) begin
            wait_empty();
        end
    endtask

    task automatic load_table();
        // Items, hold, idle cycles, expected full, wait for empty
        rows[0] = '{8'd8,  1'b0, 8'd30, 1'b0, 1'b0};
        rows[1] = '{8'd3,  1'b0, 8'd20, 1'b0, 1'b0};
        rows[2] = '{8'd1,  1'b0, 8'd30, 1'b0, 1'b0};
        rows[3] = '{8'd40, 1'b0, 8'd0,  1'b0, 1'b0};
        rows[4] = '{8'd24, 1'b1, 8'd20, 1'b0, 1'b0};
        rows[5] = '{8'd0,  1'b0, 8'd0,  1'b0, 1'b1};
        // 16 words plus 3 items, then 5 dropped
        rows[6] = '{8'd72, 1'b1, 8'd10, 1'b1, 1'b0};
        // Still full until the first read after drain_hold drops
        rows[7] = '{8'd0,  1'b0, 8'd0,  1'b1, 1'b1};
        rows[8] = '{8'd1,  1'b0, 8'd30, 1'b0, 1'b1};
    endtask

    // Output side, sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            run_len = 0;
            hold_cnt = 0;
        end else begin
            hold_cnt = drain_hold ? hold_cnt + 1 : 0;
            if (item_out_valid) begin
                run_len++;
                if (hold_cnt > HOLD_LIMIT) begin
                    check_flag(item_out_valid, 1'b0, "new batch started under drain_hold");
                end
                check_flag(empty, 1'b0, "empty while a batch is emitted");
                check_flag(logic'(emitted / batch_pkg::BATCH_LEN
                                  < accepted / batch_pkg::BATCH_LEN),
                           1'b1, "output before its batch was complete");
                if (scoreboard.size() == 0) begin
                    $display("Output item appeared with no accepted item left to match it");
                    item_errs++;
                end else begin
                    check_item(item_out, scoreboard.pop_front(), "output item");
                end
                emitted++;
            end else begin
                if (run_len != 0) begin
                    check_flag(logic'(run_len % batch_pkg::BATCH_LEN == 0), 1'b1,
                               "valid run not a whole number of batches");
                end
                run_len = 0;
            end
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        item_in = '0;
        item_valid = 1'b0;
        drain_hold = 1'b0;
        lfsr = 16'd88;
        accepted = 0;
        emitted = 0;
        run_len = 0;
        hold_cnt = 0;
        item_errs = 0;
        flag_errs = 0;
        timeouts = 0;
        load_table();

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag(empty, 1'b1, "empty after reset");
        check_flag(full, 1'b0, "full after reset");
        check_flag(item_out_valid, 1'b0, "item_out_valid after reset");

        for (int r = 0; r < NUM_ROWS && timeouts == 0; r++) begin
            apply_row(rows[r]);
        end

        if (timeouts == 0) begin
            check_flag(empty, 1'b1, "empty at end of run");
            check_flag(logic'(scoreboard.size() == 0), 1'b1, "all accepted items emitted");
        end

        $display("Errors: item %0d, flag %0d, timeout %0d", item_errs, flag_errs, timeouts);
        if (item_errs == 0 && flag_errs == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: batch_fifo.f
batch_pkg.sv
mem_pkg.sv
memory_block.sv
packing_shift_register.sv
unpacking_shift_register.sv
batch_fifo_ctrl.sv
batch_fifo.sv
tb_batch_fifo.sv

// File: Bender.yml
package:
  name: batch_fifo

sources:
  - batch_pkg.sv
  - mem_pkg.sv
  - memory_block.sv
  - packing_shift_register.sv
  - unpacking_shift_register.sv
  - batch_fifo_ctrl.sv
  - batch_fifo.sv
  - target: simulation
    files:
      - tb_batch_fifo.sv
